/* Bender.yml */
package:
  name: traceback_multi_h

sources:
  - trellis_pkg.sv
  - decision_history_stage.sv
  - traceback_sequencer.sv
  - decision_selector.sv
  - traceback_multi_h.sv
  - target: test
    files:
      - traceback_sva.sv
      - tb_traceback_multi_h.sv

/* decision_history_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module decision_history_stage (
   input  wire logic                       clk,
   input  wire logic                       reset,
   input  wire logic                       sym_en,
   input  wire trellis_pkg::decision_row_t row_in,
   input  wire trellis_pkg::state_t        cur_state,
   output trellis_pkg::decision_row_t      row_out,
   output trellis_pkg::decision_t          picked
);

   // --------------------------------------------------------------------------
   // stored survivor row
   // --------------------------------------------------------------------------

   trellis_pkg::decision_row_t row_q;

   // shifts one symbol deeper on every strobe
   always_ff @(posedge clk) begin
      if (reset) begin
         row_q <= '0;
      end
      else if (sym_en) begin
         row_q <= row_in;
      end
   end

   // next stage takes the row held here
   assign row_out = row_q;

   // --------------------------------------------------------------------------
   // pick for the traced state
   // --------------------------------------------------------------------------

   // combinational 64 to 1 mux so the walk advances one stage per cycle
   always_comb begin
      picked = row_q[cur_state];
   end

endmodule

`default_nettype wire

/* decision_selector.sv */
`timescale 1ns/1ns
`default_nettype none

module decision_selector #(
   parameter int tb_depth = 3
) (
   input  wire logic                                   clk,
   input  wire logic                                   reset,
   input  wire logic [2:0]                             step,
   input  wire trellis_pkg::decision_t                 dec_tbt_in,
   input  wire trellis_pkg::decision_t [tb_depth-1:0]  picks,
   output trellis_pkg::decision_t                      decision_tmp,
   output trellis_pkg::decision_t                      decision
);

   localparam logic [2:0] last_step = 3'(tb_depth);

   // --------------------------------------------------------------------------
   // per-step decision source
   // --------------------------------------------------------------------------

   // step 0 uses the decision handed in with the strobe
   // step j reads stage j-1
   // later steps hold on the oldest stage
   always_comb begin
      if (step == 3'd0) begin
         decision_tmp = dec_tbt_in;
      end
      else if (step <= last_step) begin
         decision_tmp = picks[step - 3'd1];
      end
      else begin
         decision_tmp = picks[tb_depth-1];
      end
   end

   // --------------------------------------------------------------------------
   // final decision
   // --------------------------------------------------------------------------

   // captured when the walk reaches the oldest row
   // an interrupted walk never gets here
   always_ff @(posedge clk) begin
      if (reset) begin
         decision <= '0;
      end
      else if (step == last_step) begin
         decision <= decision_tmp;
      end
   end

endmodule

`default_nettype wire

/* tb_traceback_multi_h.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_traceback_multi_h;

   localparam int tb_depth    = 3;
   localparam int walk_gap    = tb_depth + 2;
   localparam int short_gap   = 3;
   localparam int num_random  = 40;
   localparam int num_bursts  = 5;
   localparam int burst_len   = 5;
   localparam int num_strobes = 2 * num_random + 3 + num_bursts * burst_len;

   logic                       clk;
   logic                       reset;
   logic                       sym_en;
   logic                       sym_en_even;
   trellis_pkg::decision_t     dec_tbt_in;
   trellis_pkg::decision_row_t sel_row;
   trellis_pkg::state_t        index;
   trellis_pkg::decision_t     decision;

   integer seed;
   int     check_count;
   int     value_errors;
   int     other_errors;

   // model of the survivor history with entry 0 newest
   trellis_pkg::decision_row_t hist [0:tb_depth-1];
   trellis_pkg::decision_t     last_result;

   // one entry per strobe for the comparison process
   string                  name_q [$];
   trellis_pkg::decision_t exp_q  [$];
   trellis_pkg::decision_t hold_q [$];
   bit                     full_q [$];

   traceback_multi_h #(
      .tb_depth    (tb_depth)
   ) dut (
      .clk         (clk),
      .reset       (reset),
      .sym_en      (sym_en),
      .sym_en_even (sym_en_even),
      .dec_tbt_in  (dec_tbt_in),
      .sel_row     (sel_row),
      .index       (index),
      .decision    (decision)
   );

   always #10 clk = ~clk;

   // ---------------------------------------------------------------------------
   // reference model
   // ---------------------------------------------------------------------------

   // walk back through the model history, one row per step
   function automatic trellis_pkg::decision_t ref_walk(
      input trellis_pkg::state_t    start,
      input trellis_pkg::decision_t dec_in,
      input logic                   even
   );
      int   upper;
      int   mult;
      int   state;
      int   d;
      logic par;
      state = start;
      d     = dec_in;
      par   = even;
      for (int j = 0; j < tb_depth; j++) begin
         mult  = par ? trellis_pkg::step_even : trellis_pkg::step_odd;
         upper = ((state / 4) - mult * d) % 16;
         if (upper < 0) begin
            upper = upper + 16;
         end
         state = upper * 4 + d;
         par   = ~par;
         d     = hist[j][state];
      end
      return trellis_pkg::decision_t'(d);
   endfunction

   // ---------------------------------------------------------------------------
   // helpers
   // ---------------------------------------------------------------------------

   task automatic check_value(input string name, input trellis_pkg::decision_t exp);
      check_count++;
      assert (decision === exp)
      else begin
         value_errors++;
         $display("[ERROR] %s: expected %0d, actual %0d", name, exp, decision);
      end
   endtask

   task automatic random_row(output trellis_pkg::decision_row_t row);
      logic [127:0] flat;
      for (int w = 0; w < 4; w++) begin
         flat[w*32 +: 32] = $random(seed);
      end
      row = flat;
   endtask

   // one strobe and then idle until the next one is due
   task automatic send_symbol(
      input string                      name,
      input logic                       even,
      input trellis_pkg::decision_row_t row,
      input int                         gap
   );
      trellis_pkg::state_t    idx;
      trellis_pkg::decision_t dec_in;
      idx    = trellis_pkg::state_t'($random(seed));
      dec_in = trellis_pkg::decision_t'($random(seed));
      for (int k = tb_depth - 1; k > 0; k--) begin
         hist[k] = hist[k-1];
      end
      hist[0] = row;
      name_q.push_back(name);
      hold_q.push_back(last_result);
      full_q.push_back(gap > tb_depth);
      if (gap > tb_depth) begin
         last_result = ref_walk(idx, dec_in, even);
      end
      exp_q.push_back(last_result);
      sym_en      = 1'b1;
      sym_en_even = even;
      sel_row     = row;
      index       = idx;
      dec_tbt_in  = dec_in;
      @(posedge clk);
      #2;
      // dec_tbt_in stays for step 0
      // the rest is junk until the next strobe
      sym_en      = 1'b0;
      sym_en_even = ~even;
      sel_row     = ~row;
      index       = ~idx;
      repeat (gap - 1) begin
         @(posedge clk);
         #2;
      end
   endtask

   // ---------------------------------------------------------------------------
   // comparison
   // ---------------------------------------------------------------------------

   always begin : compare_results
      string                  cmp_name;
      trellis_pkg::decision_t cmp_exp;
      trellis_pkg::decision_t cmp_hold;
      bit                     cmp_full;
      @(posedge clk);
      if (sym_en === 1'b1) begin
         if (name_q.size() == 0) begin
            other_errors++;
            $display("strobe seen with no expected result queued");
         end
         else begin
            cmp_name = name_q.pop_front();
            cmp_exp  = exp_q.pop_front();
            cmp_hold = hold_q.pop_front();
            cmp_full = full_q.pop_front();
            #1;
            check_value({cmp_name, "_hold"}, cmp_hold);
            repeat (cmp_full ? tb_depth : short_gap - 1) begin
               @(posedge clk);
               #1;
               check_value({cmp_name, "_hold"}, cmp_hold);
            end
            if (cmp_full) begin
               @(posedge clk);
               #1;
               check_value(cmp_name, cmp_exp);
            end
         end
      end
   end

   // ---------------------------------------------------------------------------
   // stimulus
   // ---------------------------------------------------------------------------

   initial begin
      trellis_pkg::decision_row_t row;
      seed         = 32'hba01_9a6b;
      clk          = 1'b0;
      reset        = 1'b1;
      sym_en       = 1'b0;
      sym_en_even  = 1'b0;
      dec_tbt_in   = '0;
      sel_row      = '0;
      index        = '0;
      check_count  = 0;
      value_errors = 0;
      other_errors = 0;
      last_result  = '0;
      for (int k = 0; k < tb_depth; k++) begin
         hist[k] = '0;
      end
      repeat (4) @(posedge clk);
      #2;
      reset = 1'b0;
      repeat (3) begin
         check_value("reset", '0);
         @(posedge clk);
         #2;
      end
      repeat (num_random) begin
         random_row(row);
         send_symbol("even_walk", 1'b1, row, walk_gap);
      end
      repeat (num_random) begin
         random_row(row);
         send_symbol("odd_walk", 1'b0, row, walk_gap);
      end
      // constant rows so the last walk must land on the oldest one
      send_symbol("history_depth", 1'b1, {64{2'd3}}, walk_gap);
      send_symbol("history_depth", 1'b0, {64{2'd1}}, walk_gap);
      send_symbol("history_depth", 1'b1, {64{2'd2}}, walk_gap);
      for (int b = 0; b < num_bursts; b++) begin
         for (int i = 0; i < burst_len; i++) begin
            random_row(row);
            send_symbol("interrupted", b[0], row, (i == burst_len - 1) ? walk_gap : short_gap);
         end
      end
      repeat (walk_gap) @(posedge clk);
      if (name_q.size() != 0) begin
         other_errors++;
         $display("%0d queued results were never compared", name_q.size());
      end
      $display("checks=%0d value_errors=%0d other_errors=%0d assertion_failures=%0d",
               check_count, value_errors, other_errors, dut.u_selector.u_sva.fail_count);
      if (value_errors + other_errors + dut.u_selector.u_sva.fail_count == 0) begin
         $display("PASS: all tests");
      end
      else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   // watchdog
   initial begin
      repeat (num_strobes * 8 + 50) @(posedge clk);
      $display("timeout: run did not finish within %0d cycles", num_strobes * 8 + 50);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire

/* traceback_multi_h.sv */
`timescale 1ns/1ns
`default_nettype none

module traceback_multi_h #(
   parameter int tb_depth = 3
) (
   input  wire logic                       clk,
   input  wire logic                       reset,
   input  wire logic                       sym_en,
   input  wire logic                       sym_en_even,
   input  wire trellis_pkg::decision_t     dec_tbt_in,
   input  wire trellis_pkg::decision_row_t sel_row,
   input  wire trellis_pkg::state_t        index,
   output trellis_pkg::decision_t          decision
);

   trellis_pkg::state_t                   cur_state;
   logic [2:0]                            step;
   trellis_pkg::decision_t                decision_tmp;
   trellis_pkg::decision_t [tb_depth-1:0] picks;

   // row_chain[k] feeds stage k and entry 0 is the incoming row
   trellis_pkg::decision_row_t row_chain [0:tb_depth];

   assign row_chain[0] = sel_row;

   // --------------------------------------------------------------------------
   // state walk
   // --------------------------------------------------------------------------

   traceback_sequencer #(
      .tb_depth     (tb_depth)
   ) u_sequencer (
      .clk          (clk),
      .reset        (reset),
      .sym_en       (sym_en),
      .sym_en_even  (sym_en_even),
      .index        (index),
      .decision_tmp (decision_tmp),
      .cur_state    (cur_state),
      .step         (step)
   );

   // --------------------------------------------------------------------------
   // survivor history with stage 0 newest
   // --------------------------------------------------------------------------

   for (genvar k = 0; k < tb_depth; k++) begin : g_stage
      decision_history_stage u_stage (
         .clk       (clk),
         .reset     (reset),
         .sym_en    (sym_en),
         .row_in    (row_chain[k]),
         .cur_state (cur_state),
         .row_out   (row_chain[k+1]),
         .picked    (picks[k])
      );
   end

   // --------------------------------------------------------------------------
   // decision out
   // --------------------------------------------------------------------------

   decision_selector #(
      .tb_depth     (tb_depth)
   ) u_selector (
      .clk          (clk),
      .reset        (reset),
      .step         (step),
      .dec_tbt_in   (dec_tbt_in),
      .picks        (picks),
      .decision_tmp (decision_tmp),
      .decision     (decision)
   );

endmodule

`default_nettype wire

/* traceback_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module traceback_sequencer #(
   parameter int tb_depth = 3
) (
   input  wire logic                    clk,
   input  wire logic                    reset,
   input  wire logic                    sym_en,
   input  wire logic                    sym_en_even,
   input  wire trellis_pkg::state_t     index,
   input  wire trellis_pkg::decision_t  decision_tmp,
   output trellis_pkg::state_t          cur_state,
   output logic [2:0]                   step
);

   // step count parks one past the last stage
   localparam logic [2:0] step_max = 3'(tb_depth + 1);

   logic       parity;
   logic [3:0] step_mult;
   logic [3:0] upper_next;

   trellis_pkg::state_t next_state;

   // --------------------------------------------------------------------------
   // trace step counter
   // --------------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (reset || sym_en) begin
         step <= '0;
      end
      else if (step < step_max) begin
         step <= step + 3'd1;
      end
   end

   // --------------------------------------------------------------------------
   // modulation index parity
   // --------------------------------------------------------------------------

   // reloaded per symbol and flipped every trace cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         parity <= 1'b0;
      end
      else if (sym_en) begin
         parity <= sym_en_even;
      end
      else begin
         parity <= ~parity;
      end
   end

   // --------------------------------------------------------------------------
   // backward state update
   // --------------------------------------------------------------------------

   always_comb begin
      step_mult  = parity ? 4'(trellis_pkg::step_even) : 4'(trellis_pkg::step_odd);
      // modulo 16 falls out of the 4 bit width
      upper_next = cur_state[5:2] - 4'(step_mult * decision_tmp);
      next_state = {upper_next, decision_tmp};
   end

   // start from the best metric state
   always_ff @(posedge clk) begin
      if (reset) begin
         cur_state <= '0;
      end
      else if (sym_en) begin
         cur_state <= index;
      end
      else begin
         cur_state <= next_state;
      end
   end

endmodule

`default_nettype wire

/* traceback_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module traceback_sva #(
   parameter int tb_depth = 3
) (
   input wire logic                   clk,
   input wire logic                   reset,
   input wire logic [2:0]             step,
   input wire trellis_pkg::decision_t decision
);

   int fail_count = 0;

   // result only moves on the edge that ends the last trace step
   decision_update: assert property (@(posedge clk) disable iff (reset)
      !$stable(decision) |-> $past(step) == 3'(tb_depth))
   else begin
      fail_count++;
      $error("decision changed outside the last trace step");
   end

   // counter parks one past the last stage
   step_range: assert property (@(posedge clk) disable iff (reset)
      step <= 3'(tb_depth + 1))
   else begin
      fail_count++;
      $error("trace step count ran past its limit");
   end

   reset_clear: assert property (@(posedge clk) reset |=> decision == '0)
   else begin
      fail_count++;
      $error("decision not cleared while reset held");
   end

endmodule

bind decision_selector traceback_sva #(
   .tb_depth (tb_depth)
) u_sva (
   .clk      (clk),
   .reset    (reset),
   .step     (step),
   .decision (decision)
);

`default_nettype wire

/* trellis_pkg.sv */
`default_nettype none

package trellis_pkg;

   // --------------------------------------------------------------------------
   // trellis sizes
   // --------------------------------------------------------------------------

   // 64 states with four decision values per branch
   parameter int num_states = 64;
   parameter int state_w    = 6;
   parameter int dec_w      = 2;

   // --------------------------------------------------------------------------
   // multi-h backward step
   // --------------------------------------------------------------------------

   // upper state bits move back by multiplier * decision
   parameter int step_even  = 5;
   parameter int step_odd   = 4;

   // --------------------------------------------------------------------------
   // types
   // --------------------------------------------------------------------------

   typedef logic [state_w-1:0] state_t;

   typedef logic [dec_w-1:0] decision_t;

   // entry s holds the survivor decision of state s
   typedef decision_t [num_states-1:0] decision_row_t;

endpackage

`default_nettype wire

/* verilog.f */
trellis_pkg.sv
decision_history_stage.sv
traceback_sequencer.sv
decision_selector.sv
traceback_multi_h.sv
traceback_sva.sv
tb_traceback_multi_h.sv
